// File: src/l15_adapter_macros.svh
// **********************************************************************
// Width and depth macros for the cache to L1.5 adapter
// Physical address, requester ID and port ID widths
// Depth of the D-cache invalidation FIFO
// **********************************************************************

`ifndef L15_ADAPTER_MACROS_SVH
`define L15_ADAPTER_MACROS_SVH

`define L15_PA_WIDTH          40
`define L15_ID_WIDTH          4
`define L15_PID_WIDTH         2

// Pending D-cache invalidations held for the cache
`define L15_INVAL_FIFO_DEPTH  4

`endif

// File: src/l15_adapter_pkg.sv
// **********************************************************************
// Shared types of the cache to L1.5 adapter
// Request kinds, L1.5 request and return types, L1.5 sizes
// Address, ID and data widths, per-dword byte swap
// **********************************************************************

`include "l15_adapter_macros.svh"

package l15_adapter_pkg;

    typedef enum logic [2:0] {
        IMISS    = 3'd0,
        LOAD     = 3'd1,
        STORE    = 3'd2,
        UC_LOAD  = 3'd3,
        UC_STORE = 3'd4
    } req_kind_e;

    // OpenPiton encodings
    typedef enum logic [4:0] {
        LOAD_RQ  = 5'b00000,
        STORE_RQ = 5'b00001,
        IMISS_RQ = 5'b10000
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        LOAD_RET  = 4'b0000,
        IFILL_RET = 4'b0001,
        EVICT_REQ = 4'b0011,
        ST_ACK    = 4'b0100,
        ERR_RET   = 4'b1100
    } l15_rettype_e;

    typedef enum logic [2:0] {
        SZ_1B   = 3'd0,
        SZ_2B   = 3'd1,
        SZ_4B   = 3'd2,
        SZ_8B   = 3'd3,
        SZ_16B  = 3'd4,
        SZ_LINE = 3'd7
    } l15_size_e;

    typedef logic [`L15_PA_WIDTH-1:0]  pa_t;
    typedef logic [`L15_ID_WIDTH-1:0]  req_id_t;
    typedef logic [`L15_PID_WIDTH-1:0] req_pid_t;
    typedef logic                      l15_tid_t;
    typedef logic [63:0]               dword_t;
    typedef logic [7:0]                be_t;
    typedef logic [127:0]              rdata_t;

    // L1.5 is big-endian, cache side is little-endian
    function automatic dword_t swap_bytes64(dword_t d);
        dword_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return r;
    endfunction

endpackage

// File: src/l15_req_encoder.sv
// **********************************************************************
// Cache request to L1.5 request translation, purely combinational
// Request kind to L1.5 type and size, non-cacheable flag
// Store byte-enable to size and aligned address, data replication
// **********************************************************************

module l15_req_encoder (
    input  l15_adapter_pkg::req_kind_e   req_kind_i,
    input  l15_adapter_pkg::pa_t         req_addr_i,
    input  logic                         req_cacheable_i,
    input  l15_adapter_pkg::l15_size_e   req_size_i,
    input  l15_adapter_pkg::dword_t      req_wdata_i,
    input  l15_adapter_pkg::be_t         req_be_i,
    output l15_adapter_pkg::l15_rqtype_e l15_rqtype_o,
    output logic                         l15_nc_o,
    output l15_adapter_pkg::l15_size_e   l15_size_o,
    output l15_adapter_pkg::pa_t         l15_address_o,
    output l15_adapter_pkg::dword_t      l15_data_o
);

    localparam int PaW = $bits(l15_adapter_pkg::pa_t);

    logic                       is_store;
    logic [2:0]                 top_be;      // Highest set byte enable
    logic [3:0]                 num_be;
    logic [2:0]                 st_offset;
    l15_adapter_pkg::l15_size_e st_size;
    l15_adapter_pkg::pa_t       st_addr;
    l15_adapter_pkg::dword_t    st_data;

    assign is_store = (req_kind_i == l15_adapter_pkg::STORE) ||
                      (req_kind_i == l15_adapter_pkg::UC_STORE);
    assign num_be   = 4'($countones(req_be_i));

    always_comb begin
        top_be = '0;
        for (int i = 0; i < 8; i++) begin
            if (req_be_i[i]) top_be = 3'(i);
        end
    end

    // Store size and offset from the byte-enable mask
    always_comb begin
        st_offset = '0;
        unique case (num_be)
            4'd1: st_size = l15_adapter_pkg::SZ_1B;
            4'd2: st_size = l15_adapter_pkg::SZ_2B;
            4'd4: st_size = l15_adapter_pkg::SZ_4B;
            4'd8: st_size = l15_adapter_pkg::SZ_8B;
            default: st_size = l15_adapter_pkg::SZ_LINE;
        endcase
        if (num_be == 4'd1) st_offset = top_be;
        else if (num_be == 4'd2) st_offset = top_be - 3'd1;
        else if (num_be == 4'd4) st_offset = top_be - 3'd3;
    end

    assign st_addr = (num_be inside {4'd1, 4'd2, 4'd4}) ?
                     {req_addr_i[PaW-1:3], st_offset} : req_addr_i;

    // Repeat the selected bytes over the whole dword
    always_comb begin
        unique case (st_size)
            l15_adapter_pkg::SZ_1B: st_data = {8{req_wdata_i[{st_offset, 3'b000} +: 8]}};
            l15_adapter_pkg::SZ_2B: st_data = {4{req_wdata_i[{st_offset[2:1], 4'b0000} +: 16]}};
            l15_adapter_pkg::SZ_4B: st_data = {2{req_wdata_i[{st_offset[2], 5'b00000} +: 32]}};
            default: st_data = req_wdata_i;
        endcase
    end

    always_comb begin
        unique case (req_kind_i)
            l15_adapter_pkg::IMISS: begin
                l15_rqtype_o = l15_adapter_pkg::IMISS_RQ;
                l15_size_o   = req_cacheable_i ? l15_adapter_pkg::SZ_LINE
                                               : l15_adapter_pkg::SZ_4B;
            end
            l15_adapter_pkg::STORE, l15_adapter_pkg::UC_STORE: begin
                l15_rqtype_o = l15_adapter_pkg::STORE_RQ;
                l15_size_o   = st_size;
            end
            default: begin
                l15_rqtype_o = l15_adapter_pkg::LOAD_RQ;
                l15_size_o   = (req_size_i == l15_adapter_pkg::SZ_16B) ?
                               l15_adapter_pkg::SZ_LINE : req_size_i;
            end
        endcase
    end

    assign l15_nc_o      = ~req_cacheable_i;
    assign l15_address_o = is_store ? st_addr : req_addr_i;
    assign l15_data_o    = l15_adapter_pkg::swap_bytes64(is_store ? st_data : req_wdata_i);

endmodule

// File: src/l15_thread_table.sv
// **********************************************************************
// L1.5 thread ID tracking for two requests in flight
// Busy bit, requester ID and port ID per thread ID
// Request gating, lowest-free allocation and return lookup
// **********************************************************************

module l15_thread_table (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_valid_i,
    input  logic                      l15_ack_i,
    input  l15_adapter_pkg::req_id_t  req_id_i,
    input  l15_adapter_pkg::req_pid_t req_pid_i,
    input  logic                      release_i,
    input  l15_adapter_pkg::l15_tid_t rtrn_tid_i,
    output logic                      req_ready_o,
    output logic                      l15_val_o,
    output l15_adapter_pkg::l15_tid_t alloc_tid_o,
    output l15_adapter_pkg::req_id_t  resp_id_o,
    output l15_adapter_pkg::req_pid_t resp_pid_o
);

    logic [1:0]                busy_q, busy_d;
    l15_adapter_pkg::req_id_t  id_q  [2];
    l15_adapter_pkg::req_pid_t pid_q [2];
    logic                      slot_free;
    logic                      accept;

    assign slot_free   = ~(&busy_q);
    assign alloc_tid_o = busy_q[0];     // Slot 0 first
    assign req_ready_o = l15_ack_i & slot_free;
    assign l15_val_o   = req_valid_i & slot_free;
    assign accept      = l15_val_o & l15_ack_i;

    // Return lookup
    assign resp_id_o  = id_q[rtrn_tid_i];
    assign resp_pid_o = pid_q[rtrn_tid_i];

    // Accept and release never hit the same slot
    always_comb begin
        busy_d = busy_q;
        if (release_i) busy_d[rtrn_tid_i] = 1'b0;
        if (accept) busy_d[alloc_tid_o] = 1'b1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_q[alloc_tid_o]  <= req_id_i;
            pid_q[alloc_tid_o] <= req_pid_i;
        end
    end

    // A return must name a thread ID that was handed out
    a_release_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        release_i |-> busy_q[rtrn_tid_i]
    ) else $error("Release of a free L1.5 thread ID");

endmodule

// File: src/l15_resp_decoder.sv
// **********************************************************************
// L1.5 return decoding, purely combinational
// Response valid, return acknowledge and thread release
// Error flag, read data byte swap, invalidation split
// **********************************************************************

module l15_resp_decoder (
    input  logic                          rtrn_val_i,
    input  l15_adapter_pkg::l15_rettype_e returntype_i,
    input  logic                          inval_icache_i,
    input  logic                          inval_dcache_i,
    input  l15_adapter_pkg::pa_t          inval_addr_i,
    input  l15_adapter_pkg::rdata_t       rdata_i,
    input  logic                          resp_ready_i,
    input  logic                          fifo_not_full_i,
    input  l15_adapter_pkg::req_pid_t     table_pid_i,
    output logic                          resp_valid_o,
    output logic                          rtrn_ack_o,
    output logic                          release_o,
    output logic                          fifo_push_o,
    output logic                          resp_error_o,
    output l15_adapter_pkg::req_pid_t     resp_pid_o,
    output l15_adapter_pkg::rdata_t       resp_data_o,
    output l15_adapter_pkg::pa_t          resp_inval_addr_o
);

    localparam int PaW = $bits(l15_adapter_pkg::pa_t);

    logic evict_only;   // Invalidation with no data response

    assign evict_only = (returntype_i == l15_adapter_pkg::EVICT_REQ);

    assign resp_valid_o = inval_dcache_i ? (evict_only ? 1'b0 : rtrn_val_i & fifo_not_full_i)
                                         : rtrn_val_i;
    assign rtrn_ack_o   = inval_dcache_i ?
                          rtrn_val_i & fifo_not_full_i & (evict_only | resp_ready_i) :
                          rtrn_val_i & resp_ready_i;

    assign release_o    = resp_valid_o & resp_ready_i & ~evict_only;
    assign fifo_push_o  = rtrn_ack_o & inval_dcache_i;
    assign resp_error_o = (returntype_i == l15_adapter_pkg::ERR_RET);

    // I-cache invalidations go to port 0
    assign resp_pid_o = (evict_only & inval_icache_i) ? '0 : table_pid_i;

    assign resp_data_o = {l15_adapter_pkg::swap_bytes64(rdata_i[127:64]),
                          l15_adapter_pkg::swap_bytes64(rdata_i[63:0])};

    assign resp_inval_addr_o = inval_icache_i ? {inval_addr_i[PaW-1:4], 4'b0000}
                                              : inval_addr_i;

endmodule

// File: src/l15_inval_fifo.sv
// **********************************************************************
// Register FIFO of pending D-cache invalidation line addresses
// Circular buffer with read and write pointers and a fill count
// **********************************************************************

module l15_inval_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  l15_adapter_pkg::pa_t push_addr_i,
    output logic                 not_full_o,
    input  logic                 pop_i,
    output logic                 valid_o,
    output l15_adapter_pkg::pa_t addr_o
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    l15_adapter_pkg::pa_t mem_q [DEPTH];
    logic [PtrW-1:0]      wptr_q, rptr_q;
    logic [CntW-1:0]      count_q;
    logic                 do_pop;

    assign valid_o    = (count_q != '0);
    assign not_full_o = (count_q != CntW'(DEPTH));
    assign addr_o     = mem_q[rptr_q];
    assign do_pop     = pop_i & valid_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) wptr_q <= (wptr_q == PtrW'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            if (do_pop) rptr_q <= (rptr_q == PtrW'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            if (push_i && !do_pop) count_q <= count_q + 1'b1;
            else if (!push_i && do_pop) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wptr_q] <= push_addr_i;
    end

    // The return acknowledge must hold back a full FIFO
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push_i |-> not_full_o
    ) else $error("Invalidation pushed into a full FIFO");

endmodule

// File: src/l15_adapter_top.sv
// **********************************************************************
// Cache memory port to OpenPiton L1.5 adapter, top level
// Request encoder, thread table, return decoder, invalidation FIFO
// **********************************************************************

`include "l15_adapter_macros.svh"

module l15_adapter_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // Cache request
    input  logic                          req_valid_i,
    input  l15_adapter_pkg::req_kind_e    req_kind_i,
    input  l15_adapter_pkg::req_id_t      req_id_i,
    input  l15_adapter_pkg::req_pid_t     req_pid_i,
    input  l15_adapter_pkg::pa_t          req_addr_i,
    input  logic                          req_cacheable_i,
    input  l15_adapter_pkg::l15_size_e    req_size_i,
    input  l15_adapter_pkg::dword_t       req_wdata_i,
    input  l15_adapter_pkg::be_t          req_be_i,
    output logic                          req_ready_o,
    // L1.5 request
    output logic                          l15_val_o,
    output l15_adapter_pkg::l15_rqtype_e  l15_rqtype_o,
    output logic                          l15_nc_o,
    output l15_adapter_pkg::l15_size_e    l15_size_o,
    output l15_adapter_pkg::l15_tid_t     l15_threadid_o,
    output l15_adapter_pkg::pa_t          l15_address_o,
    output l15_adapter_pkg::dword_t       l15_data_o,
    input  logic                          l15_ack_i,
    // L1.5 return
    input  logic                          l15_rtrn_val_i,
    input  l15_adapter_pkg::l15_rettype_e l15_returntype_i,
    input  l15_adapter_pkg::l15_tid_t     l15_rtrn_tid_i,
    input  l15_adapter_pkg::rdata_t       l15_rdata_i,
    input  logic                          l15_inval_icache_i,
    input  logic                          l15_inval_dcache_i,
    input  l15_adapter_pkg::pa_t          l15_inval_addr_i,
    output logic                          l15_req_ack_o,
    // Cache response
    output logic                          resp_valid_o,
    output l15_adapter_pkg::req_id_t      resp_id_o,
    output l15_adapter_pkg::req_pid_t     resp_pid_o,
    output logic                          resp_error_o,
    output l15_adapter_pkg::rdata_t       resp_data_o,
    output logic                          resp_inval_icache_o,
    output logic                          resp_inval_dcache_o,
    output l15_adapter_pkg::pa_t          resp_inval_addr_o,
    input  logic                          resp_ready_i,
    // D-cache invalidation queue
    output logic                          inval_valid_o,
    output l15_adapter_pkg::pa_t          inval_addr_o,
    input  logic                          inval_ready_i
);

    logic                      release_slot;
    logic                      fifo_push;
    logic                      fifo_not_full;
    l15_adapter_pkg::req_pid_t table_pid;

    assign resp_inval_icache_o = l15_inval_icache_i;
    assign resp_inval_dcache_o = l15_inval_dcache_i;

    l15_req_encoder u_req_encoder (
        .req_kind_i      (req_kind_i),
        .req_addr_i      (req_addr_i),
        .req_cacheable_i (req_cacheable_i),
        .req_size_i      (req_size_i),
        .req_wdata_i     (req_wdata_i),
        .req_be_i        (req_be_i),
        .l15_rqtype_o    (l15_rqtype_o),
        .l15_nc_o        (l15_nc_o),
        .l15_size_o      (l15_size_o),
        .l15_address_o   (l15_address_o),
        .l15_data_o      (l15_data_o)
    );

    l15_thread_table u_thread_table (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .l15_ack_i   (l15_ack_i),
        .req_id_i    (req_id_i),
        .req_pid_i   (req_pid_i),
        .release_i   (release_slot),
        .rtrn_tid_i  (l15_rtrn_tid_i),
        .req_ready_o (req_ready_o),
        .l15_val_o   (l15_val_o),
        .alloc_tid_o (l15_threadid_o),
        .resp_id_o   (resp_id_o),
        .resp_pid_o  (table_pid)
    );

    l15_resp_decoder u_resp_decoder (
        .rtrn_val_i        (l15_rtrn_val_i),
        .returntype_i      (l15_returntype_i),
        .inval_icache_i    (l15_inval_icache_i),
        .inval_dcache_i    (l15_inval_dcache_i),
        .inval_addr_i      (l15_inval_addr_i),
        .rdata_i           (l15_rdata_i),
        .resp_ready_i      (resp_ready_i),
        .fifo_not_full_i   (fifo_not_full),
        .table_pid_i       (table_pid),
        .resp_valid_o      (resp_valid_o),
        .rtrn_ack_o        (l15_req_ack_o),
        .release_o         (release_slot),
        .fifo_push_o       (fifo_push),
        .resp_error_o      (resp_error_o),
        .resp_pid_o        (resp_pid_o),
        .resp_data_o       (resp_data_o),
        .resp_inval_addr_o (resp_inval_addr_o)
    );

    l15_inval_fifo #(
        .DEPTH (`L15_INVAL_FIFO_DEPTH)
    ) u_inval_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (fifo_push),
        .push_addr_i (resp_inval_addr_o),
        .not_full_o  (fifo_not_full),
        .pop_i       (inval_ready_i),
        .valid_o     (inval_valid_o),
        .addr_o      (inval_addr_o)
    );

endmodule

// File: dv/tb_l15_adapter.sv
// **********************************************************************
// Testbench for the cache to L1.5 adapter
// Store shaping table, load and IMISS translation, thread tracking
// Return data and error, D-cache invalidation FIFO, I-cache invalidation
// Watchdog bounded by the table length
// **********************************************************************

`include "l15_adapter_macros.svh"

module tb_l15_adapter;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ROWS = 10;
    localparam int WATCHDOG_CYCLES = (N_ROWS + 40) * 10;
    localparam int FIFO_DEPTH = `L15_INVAL_FIFO_DEPTH;

    typedef struct packed {
        logic [39:0] addr;
        logic [7:0]  mask;
        logic [2:0]  exp_size;
        logic [39:0] exp_addr;
    } store_row_t;

    // Store cases: address, byte mask, expected size and address
    localparam store_row_t STORE_ROWS [N_ROWS] = '{
        '{40'h80_0000_1235, 8'h01, 3'd0, 40'h80_0000_1230},
        '{40'h80_0000_1235, 8'h20, 3'd0, 40'h80_0000_1235},
        '{40'h80_0000_1235, 8'h80, 3'd0, 40'h80_0000_1237},
        '{40'h80_0000_1235, 8'h0c, 3'd1, 40'h80_0000_1232},
        '{40'h80_0000_1235, 8'hc0, 3'd1, 40'h80_0000_1236},
        '{40'h80_0000_1235, 8'h0f, 3'd2, 40'h80_0000_1230},
        '{40'h80_0000_1235, 8'hf0, 3'd2, 40'h80_0000_1234},
        '{40'h80_0000_1235, 8'hff, 3'd3, 40'h80_0000_1235},
        '{40'h80_0000_1235, 8'h07, 3'd7, 40'h80_0000_1235},  // Odd count goes to a line
        '{40'h80_0000_1235, 8'h00, 3'd7, 40'h80_0000_1235}
    };

    logic clk_i;
    logic rst_ni;
    logic req_valid_i;
    l15_adapter_pkg::req_kind_e req_kind_i;
    logic [3:0] req_id_i;
    logic [1:0] req_pid_i;
    logic [39:0] req_addr_i;
    logic req_cacheable_i;
    l15_adapter_pkg::l15_size_e req_size_i;
    logic [63:0] req_wdata_i;
    logic [7:0] req_be_i;
    logic req_ready_o;
    logic l15_val_o;
    l15_adapter_pkg::l15_rqtype_e l15_rqtype_o;
    logic l15_nc_o;
    l15_adapter_pkg::l15_size_e l15_size_o;
    logic l15_threadid_o;
    logic [39:0] l15_address_o;
    logic [63:0] l15_data_o;
    logic l15_ack_i;
    logic l15_rtrn_val_i;
    l15_adapter_pkg::l15_rettype_e l15_returntype_i;
    logic l15_rtrn_tid_i;
    logic [127:0] l15_rdata_i;
    logic l15_inval_icache_i;
    logic l15_inval_dcache_i;
    logic [39:0] l15_inval_addr_i;
    logic l15_req_ack_o;
    logic resp_valid_o;
    logic [3:0] resp_id_o;
    logic [1:0] resp_pid_o;
    logic resp_error_o;
    logic [127:0] resp_data_o;
    logic resp_inval_icache_o;
    logic resp_inval_dcache_o;
    logic [39:0] resp_inval_addr_o;
    logic resp_ready_i;
    logic inval_valid_o;
    logic [39:0] inval_addr_o;
    logic inval_ready_i;

    int n_checks;
    int n_errors;
    int test_start_errors;
    logic [31:0] rng;
    logic [39:0] exp_fifo[$];

    l15_adapter_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Replicate the selected bytes, then reverse byte order for the L1.5
    function automatic logic [63:0] expected_store_data(logic [63:0] d, logic [2:0] size,
                                                        logic [2:0] off);
        int nb;
        int base;
        logic [63:0] rep;
        logic [63:0] rev;
        nb = (size <= 3'd2) ? (1 << size) : 8;
        base = (nb == 8) ? 0 : int'(off);
        for (int j = 0; j < 8; j++) rep[8*j +: 8] = d[8*(base + j % nb) +: 8];
        for (int k = 0; k < 8; k++) rev[8*k +: 8] = rep[8*(7-k) +: 8];
        return rev;
    endfunction

    function automatic logic [127:0] reverse_dword_bytes(logic [127:0] d);
        logic [127:0] r;
        for (int b = 0; b < 16; b++) r[8*b +: 8] = d[8*((b / 8) * 8 + 7 - b % 8) +: 8];
        return r;
    endfunction

    task automatic expect_eq(input string sig, input logic [127:0] got,
                             input logic [127:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s got=%h exp=%h at %0t", sig, got, exp, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic settle();
        #4;     // Sample well before the next edge
    endtask

    task automatic begin_test();
        test_start_errors = n_errors;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d mismatches", name, n_errors - test_start_errors);
    endtask

    task automatic set_return(input logic val, input l15_adapter_pkg::l15_rettype_e rtype,
                              input logic tid, input logic ic, input logic dc,
                              input logic [39:0] addr);
        l15_rtrn_val_i = val;
        l15_returntype_i = rtype;
        l15_rtrn_tid_i = tid;
        l15_inval_icache_i = ic;
        l15_inval_dcache_i = dc;
        l15_inval_addr_i = addr;
    endtask

    task automatic check_load(input l15_adapter_pkg::req_kind_e kind, input logic cacheable,
                              input l15_adapter_pkg::l15_size_e size, input logic [4:0] exp_type,
                              input logic [2:0] exp_size);
        next_cycle();
        req_kind_i = kind;
        req_cacheable_i = cacheable;
        req_size_i = size;
        req_addr_i = 40'h3f_0000_0a48;
        settle();
        expect_eq("l15_rqtype_o", l15_rqtype_o, exp_type);
        expect_eq("l15_nc_o", l15_nc_o, !cacheable);
        expect_eq("l15_size_o", l15_size_o, exp_size);
        expect_eq("l15_address_o", l15_address_o, req_addr_i);
    endtask

    // One accepted request, checked before the edge that takes it
    task automatic issue_request(input logic [3:0] id, input logic [1:0] pid, input logic tid);
        next_cycle();
        l15_rtrn_val_i = 1'b0;
        req_valid_i = 1'b1;
        l15_ack_i = 1'b1;
        req_kind_i = l15_adapter_pkg::LOAD;
        req_id_i = id;
        req_pid_i = pid;
        settle();
        expect_eq("l15_val_o", l15_val_o, 1'b1);
        expect_eq("req_ready_o", req_ready_o, 1'b1);
        expect_eq("l15_threadid_o", l15_threadid_o, tid);
    endtask

    initial begin
        logic [39:0] addr;
        logic [2:0] off;
        n_checks = 0;
        n_errors = 0;
        rng = 32'h286f5506;
        rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_kind_i = l15_adapter_pkg::LOAD;
        req_id_i = '0;
        req_pid_i = '0;
        req_addr_i = '0;
        req_cacheable_i = 1'b1;
        req_size_i = l15_adapter_pkg::SZ_8B;
        req_wdata_i = '0;
        req_be_i = '0;
        l15_ack_i = 1'b0;
        l15_rdata_i = '0;
        resp_ready_i = 1'b0;
        inval_ready_i = 1'b0;
        set_return(1'b0, l15_adapter_pkg::LOAD_RET, 1'b0, 1'b0, 1'b0, '0);
        repeat (4) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        begin_test();
        expect_eq("inval_valid_o", inval_valid_o, 1'b0);
        for (int r = 0; r < N_ROWS; r++) begin
            next_cycle();
            rng = xorshift32(rng);
            req_wdata_i[63:32] = rng;
            rng = xorshift32(rng);
            req_wdata_i[31:0] = rng;
            req_kind_i = l15_adapter_pkg::STORE;
            req_addr_i = STORE_ROWS[r].addr;
            req_be_i = STORE_ROWS[r].mask;
            settle();
            off = STORE_ROWS[r].exp_addr[2:0];
            expect_eq("l15_rqtype_o", l15_rqtype_o, l15_adapter_pkg::STORE_RQ);
            expect_eq("l15_size_o", l15_size_o, STORE_ROWS[r].exp_size);
            expect_eq("l15_address_o", l15_address_o, STORE_ROWS[r].exp_addr);
            expect_eq("l15_data_o", l15_data_o,
                      expected_store_data(req_wdata_i, STORE_ROWS[r].exp_size, off));
        end
        end_test("store_shaping");

        begin_test();
        check_load(l15_adapter_pkg::IMISS, 1'b1, l15_adapter_pkg::SZ_8B,
                   l15_adapter_pkg::IMISS_RQ, 3'd7);
        check_load(l15_adapter_pkg::IMISS, 1'b0, l15_adapter_pkg::SZ_8B,
                   l15_adapter_pkg::IMISS_RQ, 3'd2);
        check_load(l15_adapter_pkg::LOAD, 1'b1, l15_adapter_pkg::SZ_16B,
                   l15_adapter_pkg::LOAD_RQ, 3'd7);
        check_load(l15_adapter_pkg::LOAD, 1'b1, l15_adapter_pkg::SZ_8B,
                   l15_adapter_pkg::LOAD_RQ, 3'd3);
        check_load(l15_adapter_pkg::UC_LOAD, 1'b0, l15_adapter_pkg::SZ_4B,
                   l15_adapter_pkg::LOAD_RQ, 3'd2);
        end_test("load_imiss");

        begin_test();
        issue_request(4'h3, 2'd1, 1'b0);
        issue_request(4'ha, 2'd2, 1'b1);
        next_cycle();
        req_id_i = 4'h5;    // Still valid, but no slot left
        settle();
        expect_eq("req_ready_o", req_ready_o, 1'b0);
        expect_eq("l15_val_o", l15_val_o, 1'b0);
        next_cycle();
        req_valid_i = 1'b0;
        resp_ready_i = 1'b1;
        set_return(1'b1, l15_adapter_pkg::LOAD_RET, 1'b1, 1'b0, 1'b0, '0);
        settle();
        expect_eq("resp_valid_o", resp_valid_o, 1'b1);
        expect_eq("resp_id_o", resp_id_o, 4'ha);
        expect_eq("resp_pid_o", resp_pid_o, 2'd2);
        expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b1);
        next_cycle();
        l15_rtrn_val_i = 1'b0;
        settle();
        expect_eq("req_ready_o", req_ready_o, 1'b1);
        expect_eq("l15_threadid_o", l15_threadid_o, 1'b1);
        next_cycle();
        set_return(1'b1, l15_adapter_pkg::LOAD_RET, 1'b0, 1'b0, 1'b0, '0);
        settle();
        expect_eq("resp_id_o", resp_id_o, 4'h3);
        expect_eq("resp_pid_o", resp_pid_o, 2'd1);
        end_test("thread_tracking");

        begin_test();
        issue_request(4'h7, 2'd3, 1'b0);
        next_cycle();
        req_valid_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            l15_rdata_i[32*i +: 32] = rng;
        end
        resp_ready_i = 1'b0;
        set_return(1'b1, l15_adapter_pkg::LOAD_RET, 1'b0, 1'b0, 1'b0, '0);
        settle();
        expect_eq("resp_valid_o", resp_valid_o, 1'b1);
        expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b0);   // Held by the cache
        next_cycle();
        resp_ready_i = 1'b1;
        settle();
        expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b1);
        expect_eq("resp_id_o", resp_id_o, 4'h7);
        expect_eq("resp_error_o", resp_error_o, 1'b0);
        expect_eq("resp_data_o", resp_data_o, reverse_dword_bytes(l15_rdata_i));
        issue_request(4'h9, 2'd3, 1'b0);
        next_cycle();
        req_valid_i = 1'b0;
        set_return(1'b1, l15_adapter_pkg::ERR_RET, 1'b0, 1'b0, 1'b0, '0);
        settle();
        expect_eq("resp_error_o", resp_error_o, 1'b1);
        expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b1);
        end_test("return_data_error");

        begin_test();
        next_cycle();
        l15_rtrn_val_i = 1'b0;
        resp_ready_i = 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            next_cycle();
            rng = xorshift32(rng);
            addr = {rng[7:0], rng};
            set_return(1'b1, l15_adapter_pkg::EVICT_REQ, 1'b0, 1'b0, 1'b1, addr);
            settle();
            expect_eq("resp_valid_o", resp_valid_o, 1'b0);
            expect_eq("resp_inval_dcache_o", resp_inval_dcache_o, 1'b1);
            expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b1);
            expect_eq("inval_valid_o", inval_valid_o, i != 0);
            if (i != 0) expect_eq("inval_addr_o", inval_addr_o, exp_fifo[0]);
            exp_fifo.push_back(addr);
        end
        next_cycle();
        rng = xorshift32(rng);
        addr = {rng[15:8], rng};
        set_return(1'b1, l15_adapter_pkg::EVICT_REQ, 1'b0, 1'b0, 1'b1, addr);
        inval_ready_i = 1'b1;
        settle();
        expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b0);   // FIFO full
        expect_eq("inval_addr_o", inval_addr_o, exp_fifo.pop_front());
        next_cycle();
        inval_ready_i = 1'b0;
        settle();
        expect_eq("l15_req_ack_o", l15_req_ack_o, 1'b1);
        exp_fifo.push_back(addr);
        next_cycle();
        l15_rtrn_val_i = 1'b0;
        inval_ready_i = 1'b1;
        while (exp_fifo.size() > 0) begin
            settle();
            expect_eq("inval_valid_o", inval_valid_o, 1'b1);
            expect_eq("inval_addr_o", inval_addr_o, exp_fifo.pop_front());
            next_cycle();
        end
        inval_ready_i = 1'b0;
        settle();
        expect_eq("inval_valid_o", inval_valid_o, 1'b0);
        end_test("dcache_inval");

        begin_test();
        next_cycle();
        resp_ready_i = 1'b1;
        set_return(1'b1, l15_adapter_pkg::EVICT_REQ, 1'b0, 1'b1, 1'b0, 40'h5a_c3d2_e1f7);
        settle();
        expect_eq("resp_valid_o", resp_valid_o, 1'b1);
        expect_eq("resp_pid_o", resp_pid_o, 2'd0);
        expect_eq("resp_inval_icache_o", resp_inval_icache_o, 1'b1);
        expect_eq("resp_inval_dcache_o", resp_inval_dcache_o, 1'b0);
        expect_eq("resp_inval_addr_o", resp_inval_addr_o, 40'h5a_c3d2_e1f0);
        next_cycle();
        l15_rtrn_val_i = 1'b0;
        end_test("icache_inval");

        next_cycle();
        $display("checks run: %0d, mismatches: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/l15_adapter_pkg.sv
src/l15_req_encoder.sv
src/l15_thread_table.sv
src/l15_resp_decoder.sv
src/l15_inval_fifo.sv
src/l15_adapter_top.sv
dv/tb_l15_adapter.sv

// File: Makefile
# Verilator flow for the L1.5 adapter testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f files.f --top-module tb_l15_adapter -Mdir obj_dir -o sim_tb

run: build
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f files.f --top-module tb_l15_adapter

clean:
	rm -rf obj_dir $(LOG)
